// File: design/rename_pkg.sv
`default_nettype none

package rename_pkg;

  // ####################################################################
  // Register file sizes
  // ####################################################################
  localparam int NUM_LOG_REGS  = 16;
  localparam int NUM_PHY_REGS  = 32;
  localparam int NUM_FREE_TAGS = NUM_PHY_REGS - NUM_LOG_REGS;

  // ####################################################################
  // Index and tag types
  // ####################################################################
  typedef logic [$clog2(NUM_LOG_REGS)-1:0] log_reg_t;
  typedef logic [$clog2(NUM_PHY_REGS)-1:0] phy_tag_t;
  typedef logic [$clog2(NUM_FREE_TAGS):0]  free_cnt_t;  // Covers 0 to 16.

endpackage

`default_nettype wire

// File: design/rename_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map_table
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_we,

  input  log_reg_t             i_rs1 [DISP_SIZE],
  input  log_reg_t             i_rs2 [DISP_SIZE],
  input  log_reg_t             i_rd [DISP_SIZE],
  input  logic [DISP_SIZE-1:0] i_rd_vld,
  input  logic [DISP_SIZE-1:0] i_slot_vld,
  input  phy_tag_t             i_new_tag [DISP_SIZE],

  output phy_tag_t             o_rs1_tag [DISP_SIZE],
  output phy_tag_t             o_rs2_tag [DISP_SIZE],
  output phy_tag_t             o_rd_old_tag [DISP_SIZE],
  output logic [DISP_SIZE-1:0] o_rs1_byp,
  output logic [DISP_SIZE-1:0] o_rs2_byp
);

  localparam int QRY_RS1 = 0;
  localparam int QRY_RS2 = 1;
  localparam int QRY_RD  = 2;
  localparam int NUM_QRY = 3;

  phy_tag_t             r_map [NUM_LOG_REGS];
  logic [DISP_SIZE-1:0] w_wr_en;
  log_reg_t             w_qry_reg [DISP_SIZE][NUM_QRY];
  phy_tag_t             w_qry_tag [DISP_SIZE][NUM_QRY];
  logic                 w_qry_byp [DISP_SIZE][NUM_QRY];

  assign w_wr_en = i_slot_vld & i_rd_vld;

  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_slot
    assign w_qry_reg[s][QRY_RS1] = i_rs1[s];
    assign w_qry_reg[s][QRY_RS2] = i_rs2[s];
    assign w_qry_reg[s][QRY_RD]  = i_rd[s];

    assign o_rs1_tag[s]    = w_qry_tag[s][QRY_RS1];
    assign o_rs2_tag[s]    = w_qry_tag[s][QRY_RS2];
    assign o_rd_old_tag[s] = w_qry_tag[s][QRY_RD];
    assign o_rs1_byp[s]    = w_qry_byp[s][QRY_RS1];
    assign o_rs2_byp[s]    = w_qry_byp[s][QRY_RS2];
  end

  // ####################################################################
  // Table read with bypass from earlier slots of the group
  // ####################################################################
  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      for (int k = 0; k < NUM_QRY; k++) begin
        w_qry_tag[s][k] = r_map[w_qry_reg[s][k]];
        w_qry_byp[s][k] = 1'b0;
        for (int p = 0; p < s; p++) begin
          if (w_wr_en[p] && i_rd[p] == w_qry_reg[s][k]) begin  // Latest slot wins.
            w_qry_tag[s][k] = i_new_tag[p];
            w_qry_byp[s][k] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < NUM_LOG_REGS; r++) begin
        r_map[r] <= phy_tag_t'(r);  // Identity map.
      end
    end else if (i_we) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (w_wr_en[s]) begin
          r_map[i_rd[s]] <= i_new_tag[s];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic [DISP_SIZE-1:0] i_alloc_req,
  input  logic                 i_accept,
  output phy_tag_t             o_alloc_tag [DISP_SIZE],
  output logic                 o_stall,

  input  logic [DISP_SIZE-1:0] i_push_vld,
  input  phy_tag_t             i_push_tag [DISP_SIZE]
);

  localparam int IDX_W = $clog2(NUM_FREE_TAGS);

  typedef logic [IDX_W-1:0] idx_t;

  phy_tag_t  r_queue [NUM_FREE_TAGS];
  idx_t      r_head;
  idx_t      r_tail;
  free_cnt_t r_count;

  idx_t      w_alloc_idx [DISP_SIZE];
  idx_t      w_push_idx [DISP_SIZE];
  free_cnt_t w_req_cnt;
  free_cnt_t w_push_cnt;
  free_cnt_t w_pop_cnt;

  // ####################################################################
  // Slot offsets from head and tail
  // ####################################################################
  always_comb begin
    w_req_cnt = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_alloc_idx[s] = idx_t'(r_head + w_req_cnt);
      if (i_alloc_req[s]) begin
        w_req_cnt = w_req_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    w_push_cnt = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_push_idx[s] = idx_t'(r_tail + w_push_cnt);
      if (i_push_vld[s]) begin
        w_push_cnt = w_push_cnt + 1'b1;
      end
    end
  end

  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_alloc
    assign o_alloc_tag[s] = r_queue[w_alloc_idx[s]];
  end

  assign o_stall   = r_count < w_req_cnt;  // Not enough tags for the group.
  assign w_pop_cnt = i_accept ? w_req_cnt : '0;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= free_cnt_t'(NUM_FREE_TAGS);
      for (int i = 0; i < NUM_FREE_TAGS; i++) begin
        r_queue[i] <= phy_tag_t'(NUM_LOG_REGS + i);  // Tags above the logical range.
      end
    end else begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (i_push_vld[s]) begin
          r_queue[w_push_idx[s]] <= i_push_tag[s];
        end
      end
      r_head  <= idx_t'(r_head + w_pop_cnt);
      r_tail  <= idx_t'(r_tail + w_push_cnt);
      r_count <= r_count - w_pop_cnt + w_push_cnt;
    end
  end

endmodule

`default_nettype wire

// File: design/inflight_list.sv
`timescale 1ns/1ps
`default_nettype none

module inflight_list
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = 2
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  phy_tag_t               i_addr [DISP_SIZE*2],
  output logic [DISP_SIZE*2-1:0] o_valids,

  input  logic [DISP_SIZE-1:0]   i_update_fetch_vld,
  input  phy_tag_t               i_update_fetch_addr [DISP_SIZE],
  input  logic [DISP_SIZE-1:0]   i_update_fetch_data,

  input  logic [DISP_SIZE-1:0]   i_update_wb_vld,
  input  phy_tag_t               i_update_wb_addr [DISP_SIZE],
  input  logic [DISP_SIZE-1:0]   i_update_wb_data
);

  logic [NUM_PHY_REGS-1:0] r_ready;
  logic [NUM_PHY_REGS-1:0] w_fetch_hit;
  logic [NUM_PHY_REGS-1:0] w_fetch_data;
  logic [NUM_PHY_REGS-1:0] w_wb_hit;
  logic [NUM_PHY_REGS-1:0] w_wb_data;

  // ####################################################################
  // Per-tag update decode
  // ####################################################################
  for (genvar t = 0; t < NUM_PHY_REGS; t++) begin : g_tag
    logic [DISP_SIZE-1:0] w_fetch_match;
    logic [DISP_SIZE-1:0] w_wb_match;

    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_port
      assign w_fetch_match[d] = i_update_fetch_vld[d] &&
                                i_update_fetch_addr[d] == phy_tag_t'(t);
      assign w_wb_match[d]    = i_update_wb_vld[d] && i_update_wb_addr[d] == phy_tag_t'(t);
    end

    assign w_fetch_hit[t]  = |w_fetch_match;
    assign w_fetch_data[t] = |(w_fetch_match & i_update_fetch_data);
    assign w_wb_hit[t]     = |w_wb_match;
    assign w_wb_data[t]    = |(w_wb_match & i_update_wb_data);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      for (int t = 0; t < NUM_PHY_REGS; t++) begin
        if (w_fetch_hit[t]) begin
          r_ready[t] <= w_fetch_data[t];  // Dispatch clear wins.
        end else if (w_wb_hit[t]) begin
          r_ready[t] <= w_wb_data[t];
        end
      end
    end
  end

  for (genvar k = 0; k < DISP_SIZE*2; k++) begin : g_read
    assign o_valids[k] = r_ready[i_addr[k]];  // State before the edge.
  end

endmodule

`default_nettype wire

// File: design/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic [DISP_SIZE-1:0] i_disp_vld,
  input  log_reg_t             i_disp_rs1 [DISP_SIZE],
  input  log_reg_t             i_disp_rs2 [DISP_SIZE],
  input  log_reg_t             i_disp_rd [DISP_SIZE],
  input  logic [DISP_SIZE-1:0] i_disp_rd_vld,

  input  logic [DISP_SIZE-1:0] i_wb_vld,
  input  phy_tag_t             i_wb_tag [DISP_SIZE],
  input  logic [DISP_SIZE-1:0] i_cmt_vld,
  input  phy_tag_t             i_cmt_tag [DISP_SIZE],

  output logic                 o_stall,
  output phy_tag_t             o_rs1_tag [DISP_SIZE],
  output phy_tag_t             o_rs2_tag [DISP_SIZE],
  output logic [DISP_SIZE-1:0] o_rs1_ready,
  output logic [DISP_SIZE-1:0] o_rs2_ready,
  output phy_tag_t             o_rd_tag [DISP_SIZE],
  output phy_tag_t             o_rd_old_tag [DISP_SIZE]
);

  logic                   w_accept;
  logic [DISP_SIZE-1:0]   w_alloc_req;
  logic [DISP_SIZE-1:0]   w_fetch_vld;
  phy_tag_t               w_alloc_tag [DISP_SIZE];
  phy_tag_t               w_src_tag [DISP_SIZE*2];
  logic [DISP_SIZE*2-1:0] w_valids;
  logic [DISP_SIZE-1:0]   w_rs1_byp;
  logic [DISP_SIZE-1:0]   w_rs2_byp;

  assign w_alloc_req = i_disp_vld & i_disp_rd_vld;
  assign w_accept    = |i_disp_vld && !o_stall;  // Group renamed this cycle.
  assign w_fetch_vld = w_alloc_req & {DISP_SIZE{w_accept}};

  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_slot
    assign w_src_tag[s*2]   = o_rs1_tag[s];
    assign w_src_tag[s*2+1] = o_rs2_tag[s];
    assign o_rs1_ready[s]   = w_valids[s*2] && !w_rs1_byp[s];
    assign o_rs2_ready[s]   = w_valids[s*2+1] && !w_rs2_byp[s];
    assign o_rd_tag[s]      = w_alloc_tag[s];
  end

  rename_map_table #(.DISP_SIZE(DISP_SIZE)) u_map_table (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_we(w_accept),
    .i_rs1(i_disp_rs1), .i_rs2(i_disp_rs2), .i_rd(i_disp_rd),
    .i_rd_vld(i_disp_rd_vld), .i_slot_vld(i_disp_vld), .i_new_tag(w_alloc_tag),
    .o_rs1_tag(o_rs1_tag), .o_rs2_tag(o_rs2_tag), .o_rd_old_tag(o_rd_old_tag),
    .o_rs1_byp(w_rs1_byp), .o_rs2_byp(w_rs2_byp)
  );

  free_list #(.DISP_SIZE(DISP_SIZE)) u_free_list (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_alloc_req(w_alloc_req), .i_accept(w_accept),
    .o_alloc_tag(w_alloc_tag), .o_stall(o_stall),
    .i_push_vld(i_cmt_vld), .i_push_tag(i_cmt_tag)
  );

  inflight_list #(.DISP_SIZE(DISP_SIZE)) u_inflight_list (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_addr(w_src_tag), .o_valids(w_valids),
    .i_update_fetch_vld(w_fetch_vld), .i_update_fetch_addr(w_alloc_tag),
    .i_update_fetch_data('0),
    .i_update_wb_vld(i_wb_vld), .i_update_wb_addr(i_wb_tag), .i_update_wb_data('1)
  );

endmodule

`default_nettype wire

// File: sim/rename_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage_props
  import rename_pkg::*;
#(
  parameter int DISP_SIZE = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_stall,
  input  logic                 i_accept,
  input  logic [DISP_SIZE-1:0] i_alloc_req,
  input  phy_tag_t             i_alloc_tag [DISP_SIZE],
  input  phy_tag_t             i_map [NUM_LOG_REGS]
);

  localparam int TAG_W = $bits(phy_tag_t);

  logic [NUM_LOG_REGS*TAG_W-1:0] w_map_flat;

  for (genvar r = 0; r < NUM_LOG_REGS; r++) begin : g_map
    assign w_map_flat[r*TAG_W +: TAG_W] = i_map[r];
  end

  a_no_stall_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> !i_stall)
    else $error("Stall raised in the first cycle after reset");

  a_no_write_on_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_stall |=> $stable(w_map_flat))
    else $error("Map table written while stalled");

  // Every pair of allocating slots in an accepted group.
  for (genvar a = 0; a < DISP_SIZE; a++) begin : g_a
    for (genvar b = a + 1; b < DISP_SIZE; b++) begin : g_b
      a_unique_tag: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_accept && i_alloc_req[a] && i_alloc_req[b] |-> i_alloc_tag[a] != i_alloc_tag[b])
        else $error("Slots %0d and %0d received the same tag", a, b);
    end
  end

endmodule

bind rename_stage rename_stage_props #(.DISP_SIZE(DISP_SIZE)) u_props (
  .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stall(o_stall), .i_accept(w_accept),
  .i_alloc_req(w_alloc_req), .i_alloc_tag(w_alloc_tag), .i_map(u_map_table.r_map)
);

`default_nettype wire

// File: sim/tb_rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_stage;
  import rename_pkg::*;

  localparam int DISP_SIZE       = 2;
  localparam int RAND_CYCLES     = 500;
  localparam int WATCHDOG_CYCLES = (RAND_CYCLES + 150) * 3;  // Directed tests plus margin.

  logic                 i_clk;
  logic                 i_reset_n;
  logic [DISP_SIZE-1:0] i_disp_vld;
  log_reg_t             i_disp_rs1 [DISP_SIZE];
  log_reg_t             i_disp_rs2 [DISP_SIZE];
  log_reg_t             i_disp_rd [DISP_SIZE];
  logic [DISP_SIZE-1:0] i_disp_rd_vld;
  logic [DISP_SIZE-1:0] i_wb_vld;
  phy_tag_t             i_wb_tag [DISP_SIZE];
  logic [DISP_SIZE-1:0] i_cmt_vld;
  phy_tag_t             i_cmt_tag [DISP_SIZE];
  logic                 o_stall;
  phy_tag_t             o_rs1_tag [DISP_SIZE];
  phy_tag_t             o_rs2_tag [DISP_SIZE];
  logic [DISP_SIZE-1:0] o_rs1_ready;
  logic [DISP_SIZE-1:0] o_rs2_ready;
  phy_tag_t             o_rd_tag [DISP_SIZE];
  phy_tag_t             o_rd_old_tag [DISP_SIZE];

  phy_tag_t                m_map [NUM_LOG_REGS];
  logic [NUM_PHY_REGS-1:0] m_ready;
  phy_tag_t                free_q [$];
  phy_tag_t                pend_free [$];  // Old tags waiting for commit.
  phy_tag_t                in_flight [$];  // New tags waiting for writeback.

  phy_tag_t             exp_new [DISP_SIZE];
  phy_tag_t             exp_old [DISP_SIZE];
  phy_tag_t             exp_rs1 [DISP_SIZE];
  phy_tag_t             exp_rs2 [DISP_SIZE];
  logic [DISP_SIZE-1:0] exp_rs1_rdy;
  logic [DISP_SIZE-1:0] exp_rs2_rdy;
  logic                 exp_stall;

  string test_name;
  int    checks;
  int    errors;
  int    test_errors;
  int    seed;

  rename_stage #(.DISP_SIZE(DISP_SIZE)) dut (.*);

  always #5 i_clk = ~i_clk;

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ####################################################################
  // Reference model
  // ####################################################################
  task automatic resolve(input int s, input log_reg_t r, output phy_tag_t tag, output logic byp);
    tag = m_map[r];
    byp = 1'b0;
    for (int p = 0; p < s; p++) begin
      if (i_disp_vld[p] && i_disp_rd_vld[p] && i_disp_rd[p] == r) begin  // Latest earlier slot.
        tag = exp_new[p];
        byp = 1'b1;
      end
    end
  endtask

  task automatic compute_expected();
    int   k;
    logic byp;
    k = 0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      exp_new[s] = '0;
      if (i_disp_vld[s] && i_disp_rd_vld[s]) begin
        if (k < free_q.size()) exp_new[s] = free_q[k];
        k++;
      end
    end
    exp_stall = free_q.size() < k;
    for (int s = 0; s < DISP_SIZE; s++) begin
      resolve(s, i_disp_rs1[s], exp_rs1[s], byp);
      exp_rs1_rdy[s] = !byp && m_ready[exp_rs1[s]];
      resolve(s, i_disp_rs2[s], exp_rs2[s], byp);
      exp_rs2_rdy[s] = !byp && m_ready[exp_rs2[s]];
      resolve(s, i_disp_rd[s], exp_old[s], byp);
    end
  endtask

  task automatic update_model();
    for (int s = 0; s < DISP_SIZE; s++) begin
      if (i_wb_vld[s]) m_ready[i_wb_tag[s]] = 1'b1;
    end
    if (|i_disp_vld && !exp_stall) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (i_disp_vld[s] && i_disp_rd_vld[s]) begin
          m_map[i_disp_rd[s]] = exp_new[s];
          m_ready[exp_new[s]] = 1'b0;  // Clear after set, so dispatch wins.
          pend_free.push_back(exp_old[s]);
          in_flight.push_back(exp_new[s]);
          free_q.delete(0);
        end
      end
    end
    for (int s = 0; s < DISP_SIZE; s++) begin
      if (i_cmt_vld[s]) free_q.push_back(i_cmt_tag[s]);
    end
  endtask

  // ####################################################################
  // Stimulus and checking
  // ####################################################################
  task automatic check(string what, logic [7:0] exp_v, logic [7:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      $display("Mismatch %s %s: expected %0d actual %0d", test_name, what, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic run_cycle();
    @(negedge i_clk);
    compute_expected();
    check("o_stall", 8'(exp_stall), 8'(o_stall));
    for (int s = 0; s < DISP_SIZE; s++) begin
      if (i_disp_vld[s] && !exp_stall) begin
        check($sformatf("slot%0d rs1 tag", s), 8'(exp_rs1[s]), 8'(o_rs1_tag[s]));
        check($sformatf("slot%0d rs2 tag", s), 8'(exp_rs2[s]), 8'(o_rs2_tag[s]));
        check($sformatf("slot%0d rs1 ready", s), 8'(exp_rs1_rdy[s]), 8'(o_rs1_ready[s]));
        check($sformatf("slot%0d rs2 ready", s), 8'(exp_rs2_rdy[s]), 8'(o_rs2_ready[s]));
        if (i_disp_rd_vld[s]) begin
          check($sformatf("slot%0d rd tag", s), 8'(exp_new[s]), 8'(o_rd_tag[s]));
          check($sformatf("slot%0d rd old tag", s), 8'(exp_old[s]), 8'(o_rd_old_tag[s]));
        end
      end
    end
    @(posedge i_clk);
    update_model();
    #1;
  endtask

  task automatic clear_inputs();
    i_disp_vld    = '0;
    i_disp_rd_vld = '0;
    i_wb_vld      = '0;
    i_cmt_vld     = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      i_disp_rs1[s] = '0;
      i_disp_rs2[s] = '0;
      i_disp_rd[s]  = '0;
      i_wb_tag[s]   = '0;
      i_cmt_tag[s]  = '0;
    end
  endtask

  task automatic set_slot(int s, int rs1, int rs2, int rd, int rd_vld);
    i_disp_vld[s]    = 1'b1;
    i_disp_rs1[s]    = log_reg_t'(rs1);
    i_disp_rs2[s]    = log_reg_t'(rs2);
    i_disp_rd[s]     = log_reg_t'(rd);
    i_disp_rd_vld[s] = (rd_vld != 0);
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
    clear_inputs();
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, test_errors);
  endtask

  initial begin
    logic [31:0] rnd;
    int          idx;
    seed      = 32'hdf13_f729;
    checks    = 0;
    errors    = 0;
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    clear_inputs();
    m_ready = '1;
    for (int r = 0; r < NUM_LOG_REGS; r++) m_map[r] = phy_tag_t'(r);
    for (int i = 0; i < NUM_FREE_TAGS; i++) free_q.push_back(phy_tag_t'(NUM_LOG_REGS + i));
    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    start_test("reset_map");
    for (int i = 0; i < NUM_LOG_REGS; i += 2) begin
      set_slot(0, i, i + 1, 0, 0);
      set_slot(1, 15 - i, 14 - i, 0, 0);
      run_cycle();
    end
    end_test();

    start_test("alloc_order");
    set_slot(0, 1, 2, 3, 1);
    set_slot(1, 4, 6, 5, 1);
    run_cycle();
    clear_inputs();
    set_slot(0, 3, 5, 8, 1);
    set_slot(1, 3, 9, 3, 1);
    run_cycle();
    clear_inputs();
    set_slot(0, 3, 8, 0, 0);
    run_cycle();
    end_test();

    start_test("group_bypass");
    set_slot(0, 1, 2, 7, 1);
    set_slot(1, 7, 7, 7, 1);
    run_cycle();
    clear_inputs();
    set_slot(0, 7, 2, 0, 0);
    run_cycle();
    end_test();

    start_test("writeback");
    set_slot(0, 7, 7, 0, 0);  // Same cycle still reads not ready.
    i_wb_vld[0] = 1'b1;
    i_wb_tag[0] = m_map[7];
    run_cycle();
    clear_inputs();
    set_slot(0, 7, 1, 0, 0);
    run_cycle();
    clear_inputs();
    set_slot(0, 2, 3, 9, 1);
    i_wb_vld[0] = 1'b1;
    i_wb_tag[0] = free_q[0];  // Collides with the dispatch clear.
    run_cycle();
    clear_inputs();
    set_slot(0, 9, 9, 0, 0);
    run_cycle();
    end_test();

    start_test("exhaust");
    while (free_q.size() >= DISP_SIZE) begin
      set_slot(0, 1, 2, 10, 1);
      set_slot(1, 10, 3, 11, 1);
      run_cycle();
    end
    set_slot(0, 12, 4, 12, 1);
    set_slot(1, 12, 13, 13, 1);
    repeat (3) run_cycle();
    clear_inputs();
    set_slot(0, 12, 13, 0, 0);
    set_slot(1, 10, 11, 0, 0);
    run_cycle();
    clear_inputs();
    set_slot(0, 12, 4, 12, 1);
    set_slot(1, 12, 13, 13, 1);
    i_cmt_vld    = '1;
    i_cmt_tag[0] = pend_free.pop_front();
    i_cmt_tag[1] = pend_free.pop_front();
    run_cycle();
    i_cmt_vld = '0;
    run_cycle();
    clear_inputs();
    set_slot(0, 12, 13, 14, 1);  // Takes the second committed tag.
    set_slot(1, 14, 1, 15, 0);
    run_cycle();
    end_test();

    start_test("random_mix");
    for (int c = 0; c < RAND_CYCLES; c++) begin
      clear_inputs();
      for (int s = 0; s < DISP_SIZE; s++) begin
        rnd              = $random(seed);
        i_disp_vld[s]    = rnd[0];
        i_disp_rd_vld[s] = rnd[1];
        i_disp_rs1[s]    = rnd[5:2];
        i_disp_rs2[s]    = rnd[9:6];
        i_disp_rd[s]     = rnd[13:10];
        if (rnd[14] && in_flight.size() > 0) begin
          idx         = int'(rnd[20:16]) % in_flight.size();
          i_wb_vld[s] = 1'b1;
          i_wb_tag[s] = in_flight[idx];
          in_flight.delete(idx);
        end
        if (rnd[15] && rnd[21] && pend_free.size() > 0) begin
          i_cmt_vld[s] = 1'b1;
          i_cmt_tag[s] = pend_free.pop_front();
        end
      end
      run_cycle();
    end
    end_test();

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_stage.f
design/rename_pkg.sv
design/rename_map_table.sv
design/free_list.sv
design/inflight_list.sv
design/rename_stage.sv
sim/rename_stage_props.sv
sim/tb_rename_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rename_stage
FILELIST  = rename_stage.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
